//--- Bender.yml
package:
  name: mem_route

sources:
  - files:
      - hdl/mem_route_pkg.sv
      - hdl/global_cycle_counter.sv
      - hdl/req_capture_stage.sv
      - hdl/channel_map_stage.sv
      - hdl/dram_addr_split_stage.sv
      - hdl/mem_route_top.sv
  - target: test
    files:
      - verification/mem_route_properties.sv
      - verification/mem_route_tb.sv

//--- compile.f
hdl/mem_route_pkg.sv
hdl/global_cycle_counter.sv
hdl/req_capture_stage.sv
hdl/channel_map_stage.sv
hdl/dram_addr_split_stage.sv
hdl/mem_route_top.sv
verification/mem_route_properties.sv
verification/mem_route_tb.sv

//--- hdl/channel_map_stage.sv
`timescale 1ns/1ps

module channel_map_stage
  import mem_route_pkg::*;
(
  input  logic                      core_clk,
  input  logic                      reset_i,

  // from capture stage
  input  logic                      cap_v_i,
  input  logic [CACHE_ID_W-1:0]     cap_cache_id_i,
  input  req_op_e                   cap_op_i,
  input  logic [CACHE_ADDR_W-1:0]   cap_addr_i,
  input  logic [GLOBAL_CTR_W-1:0]   cap_timestamp_i,

  // to address split stage
  output logic                      map_v_o,
  output logic [CHANNEL_ID_W-1:0]   map_channel_o,
  output req_op_e                   map_op_o,
  output logic [CHANNEL_ADDR_W-1:0] map_ch_addr_o,
  output logic [GLOBAL_CTR_W-1:0]   map_timestamp_o
);

  logic [CHANNEL_ID_W-1:0] channel_d;
  logic [LOCAL_ID_W-1:0]   local_id_d;

  // --------------------------------------------------
  // fixed grouping of caches onto channels
  // --------------------------------------------------
  // consecutive caches share a channel
  assign channel_d  = CHANNEL_ID_W'(int'(cap_cache_id_i) / CACHES_PER_CHANNEL);
  assign local_id_d = LOCAL_ID_W'(int'(cap_cache_id_i) % CACHES_PER_CHANNEL);

  always_ff @(posedge core_clk) begin
    if (reset_i) begin
      map_v_o <= 1'b0;
    end else begin
      map_v_o <= cap_v_i;
    end
  end

  // local index goes in the msbs of the channel address
  always_ff @(posedge core_clk) begin
    if (cap_v_i) begin
      map_channel_o   <= channel_d;
      map_op_o        <= cap_op_i;
      map_ch_addr_o   <= {local_id_d, cap_addr_i};
      map_timestamp_o <= cap_timestamp_i;
    end
  end

endmodule

//--- hdl/dram_addr_split_stage.sv
`timescale 1ns/1ps

module dram_addr_split_stage
  import mem_route_pkg::*;
(
  input  logic                         core_clk,
  input  logic                         reset_i,

  // from channel map stage
  input  logic                         map_v_i,
  input  logic [CHANNEL_ID_W-1:0]      map_channel_i,
  input  req_op_e                      map_op_i,
  input  logic [CHANNEL_ADDR_W-1:0]    map_ch_addr_i,
  input  logic [GLOBAL_CTR_W-1:0]      map_timestamp_i,

  // per-channel dram request
  output logic [NUM_CHANNELS_USED-1:0] dram_v_o,
  output req_op_e                      dram_op_o,
  output logic [BG_W-1:0]              dram_bg_o,
  output logic [BA_W-1:0]              dram_ba_o,
  output logic [RO_W-1:0]              dram_ro_o,
  output logic [CO_W-1:0]              dram_co_o,
  output logic [BYTE_OFFSET_W-1:0]     dram_byte_offset_o,
  output logic [GLOBAL_CTR_W-1:0]      dram_timestamp_o
);

  // --------------------------------------------------
  // channel strobe decode
  // --------------------------------------------------
  // one-hot, or all zero when idle
  always_ff @(posedge core_clk) begin
    if (reset_i) begin
      dram_v_o <= '0;
    end else begin
      for (int ch = 0; ch < NUM_CHANNELS_USED; ch++) begin
        dram_v_o[ch] <= map_v_i && (map_channel_i == CHANNEL_ID_W'(ch));
      end
    end
  end

  // --------------------------------------------------
  // address field split
  // --------------------------------------------------
  // bank group ends up holding the cache's local index
  always_ff @(posedge core_clk) begin
    if (map_v_i) begin
      dram_op_o <= map_op_i;
      {dram_bg_o, dram_ba_o, dram_ro_o, dram_co_o, dram_byte_offset_o} <= map_ch_addr_i;
      dram_timestamp_o <= map_timestamp_i;
    end
  end

endmodule

//--- hdl/global_cycle_counter.sv
`timescale 1ns/1ps

module global_cycle_counter
  import mem_route_pkg::*;
(
  input  logic                    core_clk,
  input  logic                    reset_i,
  output logic [GLOBAL_CTR_W-1:0] cycle_count_o
);

  // delayed copy of reset, matches the reset pipeline of the fabric
  logic [RESET_DEPTH-1:0] reset_chain;
  logic                   reset_delayed;

  always_ff @(posedge core_clk) begin
    reset_chain[0] <= reset_i;
    for (int i = 1; i < RESET_DEPTH; i++) begin
      reset_chain[i] <= reset_chain[i-1];
    end
  end

  assign reset_delayed = reset_chain[RESET_DEPTH-1];

  // --------------------------------------------------
  // free-running cycle counter
  // --------------------------------------------------
  // held at zero while the delayed reset is high
  always_ff @(posedge core_clk) begin
    if (reset_delayed) begin
      cycle_count_o <= '0;
    end else begin
      cycle_count_o <= cycle_count_o + 1'b1;
    end
  end

endmodule

//--- hdl/mem_route_pkg.sv
package mem_route_pkg;

  // --------------------------------------------------
  // cache to channel grouping
  // --------------------------------------------------
  localparam int NUM_CACHE          = 8;
  localparam int NUM_CHANNELS_USED  = 2;
  localparam int CACHES_PER_CHANNEL = NUM_CACHE / NUM_CHANNELS_USED;

  localparam int CACHE_ID_W   = $clog2(NUM_CACHE);
  localparam int CHANNEL_ID_W = $clog2(NUM_CHANNELS_USED);
  localparam int LOCAL_ID_W   = $clog2(CACHES_PER_CHANNEL);

  // --------------------------------------------------
  // address widths
  // --------------------------------------------------
  localparam int CACHE_ADDR_W = 27;
  // local index sits above the cache bank address
  localparam int CHANNEL_ADDR_W = LOCAL_ID_W + CACHE_ADDR_W;

  // dram fields, msb to lsb: bg, ba, ro, co, byte offset
  localparam int BG_W          = 2;
  localparam int BA_W          = 2;
  localparam int RO_W          = 14;
  localparam int CO_W          = 6;
  localparam int BYTE_OFFSET_W = 5;

  // --------------------------------------------------
  // timing
  // --------------------------------------------------
  localparam int GLOBAL_CTR_W = 64;
  localparam int RESET_DEPTH  = 2;
  // one register per stage, three stages
  localparam int PIPE_LATENCY = 3;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } req_op_e;

endpackage

//--- hdl/mem_route_top.sv
`timescale 1ns/1ps

module mem_route_top
  import mem_route_pkg::*;
(
  input  logic                         core_clk,
  input  logic                         reset_i,

  // request from the cache banks
  input  logic                         req_v_i,
  input  logic [CACHE_ID_W-1:0]        req_cache_id_i,
  input  req_op_e                      req_op_i,
  input  logic [CACHE_ADDR_W-1:0]      req_addr_i,

  // request to the dram channels
  output logic [NUM_CHANNELS_USED-1:0] dram_v_o,
  output req_op_e                      dram_op_o,
  output logic [BG_W-1:0]              dram_bg_o,
  output logic [BA_W-1:0]              dram_ba_o,
  output logic [RO_W-1:0]              dram_ro_o,
  output logic [CO_W-1:0]              dram_co_o,
  output logic [BYTE_OFFSET_W-1:0]     dram_byte_offset_o,
  output logic [GLOBAL_CTR_W-1:0]      dram_timestamp_o
);

  logic [GLOBAL_CTR_W-1:0]   cycle_count;

  // stage 1 outputs
  logic                      cap_v;
  logic [CACHE_ID_W-1:0]     cap_cache_id;
  req_op_e                   cap_op;
  logic [CACHE_ADDR_W-1:0]   cap_addr;
  logic [GLOBAL_CTR_W-1:0]   cap_timestamp;

  // stage 2 outputs
  logic                      map_v;
  logic [CHANNEL_ID_W-1:0]   map_channel;
  req_op_e                   map_op;
  logic [CHANNEL_ADDR_W-1:0] map_ch_addr;
  logic [GLOBAL_CTR_W-1:0]   map_timestamp;

  // --------------------------------------------------
  // global time
  // --------------------------------------------------
  global_cycle_counter global_cc (
    .core_clk      (core_clk),
    .reset_i       (reset_i),
    .cycle_count_o (cycle_count)
  );

  // --------------------------------------------------
  // request pipeline
  // --------------------------------------------------
  req_capture_stage capture (
    .core_clk        (core_clk),
    .reset_i         (reset_i),
    .req_v_i         (req_v_i),
    .req_cache_id_i  (req_cache_id_i),
    .req_op_i        (req_op_i),
    .req_addr_i      (req_addr_i),
    .cycle_count_i   (cycle_count),
    .cap_v_o         (cap_v),
    .cap_cache_id_o  (cap_cache_id),
    .cap_op_o        (cap_op),
    .cap_addr_o      (cap_addr),
    .cap_timestamp_o (cap_timestamp)
  );

  channel_map_stage chan_map (
    .core_clk        (core_clk),
    .reset_i         (reset_i),
    .cap_v_i         (cap_v),
    .cap_cache_id_i  (cap_cache_id),
    .cap_op_i        (cap_op),
    .cap_addr_i      (cap_addr),
    .cap_timestamp_i (cap_timestamp),
    .map_v_o         (map_v),
    .map_channel_o   (map_channel),
    .map_op_o        (map_op),
    .map_ch_addr_o   (map_ch_addr),
    .map_timestamp_o (map_timestamp)
  );

  dram_addr_split_stage addr_split (
    .core_clk           (core_clk),
    .reset_i            (reset_i),
    .map_v_i            (map_v),
    .map_channel_i      (map_channel),
    .map_op_i           (map_op),
    .map_ch_addr_i      (map_ch_addr),
    .map_timestamp_i    (map_timestamp),
    .dram_v_o           (dram_v_o),
    .dram_op_o          (dram_op_o),
    .dram_bg_o          (dram_bg_o),
    .dram_ba_o          (dram_ba_o),
    .dram_ro_o          (dram_ro_o),
    .dram_co_o          (dram_co_o),
    .dram_byte_offset_o (dram_byte_offset_o),
    .dram_timestamp_o   (dram_timestamp_o)
  );

endmodule

//--- hdl/req_capture_stage.sv
`timescale 1ns/1ps

module req_capture_stage
  import mem_route_pkg::*;
(
  input  logic                      core_clk,
  input  logic                      reset_i,

  // incoming request strobe
  input  logic                      req_v_i,
  input  logic [CACHE_ID_W-1:0]     req_cache_id_i,
  input  req_op_e                   req_op_i,
  input  logic [CACHE_ADDR_W-1:0]   req_addr_i,

  // global time
  input  logic [GLOBAL_CTR_W-1:0]   cycle_count_i,

  // captured request
  output logic                      cap_v_o,
  output logic [CACHE_ID_W-1:0]     cap_cache_id_o,
  output req_op_e                   cap_op_o,
  output logic [CACHE_ADDR_W-1:0]   cap_addr_o,
  output logic [GLOBAL_CTR_W-1:0]   cap_timestamp_o
);

  // --------------------------------------------------
  // valid
  // --------------------------------------------------
  // every strobe is accepted, there is no ready
  always_ff @(posedge core_clk) begin
    if (reset_i) begin
      cap_v_o <= 1'b0;
    end else begin
      cap_v_o <= req_v_i;
    end
  end

  // --------------------------------------------------
  // payload
  // --------------------------------------------------
  // timestamp is the count in the cycle the strobe is sampled
  always_ff @(posedge core_clk) begin
    if (req_v_i) begin
      cap_cache_id_o  <= req_cache_id_i;
      cap_op_o        <= req_op_i;
      cap_addr_o      <= req_addr_i;
      cap_timestamp_o <= cycle_count_i;
    end
  end

endmodule

//--- verification/mem_route_properties.sv
`timescale 1ns/1ps

module mem_route_properties
  import mem_route_pkg::*;
(
  input logic                         core_clk,
  input logic                         reset_i,
  input logic                         req_v_i,
  input logic [NUM_CHANNELS_USED-1:0] dram_v_i
);

  // at most one channel strobed per cycle
  onehot_channel : assert property (
    @(posedge core_clk) disable iff (reset_i) $onehot0(dram_v_i)
  ) else $error("dram_v_o has more than one bit set");

  // every output strobe has a request PIPE_LATENCY cycles before it
  output_has_request : assert property (
    @(posedge core_clk) disable iff (reset_i)
      (dram_v_i != '0) |-> $past(req_v_i, PIPE_LATENCY)
  ) else $error("dram_v_o set without a request three cycles earlier");

  idle_after_reset : assert property (
    @(posedge core_clk) reset_i |=> (dram_v_i == '0)
  ) else $error("dram_v_o not zero in the cycle after reset");

endmodule

bind mem_route_top mem_route_properties props (
  .core_clk (core_clk),
  .reset_i  (reset_i),
  .req_v_i  (req_v_i),
  .dram_v_i (dram_v_o)
);

//--- verification/mem_route_tb.sv
`timescale 1ns/1ps

module mem_route_tb
  import mem_route_pkg::*;
();

  localparam int          NUM_REQ      = 200;
  localparam int          RESET_CYCLES = 5;
  localparam int unsigned SEED         = 32'hede81d8f;
  // worst case 4 cycles per request, plus reset, latency and margin
  localparam int TIMEOUT_CYCLES = NUM_REQ * 4 + RESET_CYCLES + PIPE_LATENCY + 192;

  logic                         core_clk;
  logic                         reset_i;
  logic                         req_v_i;
  logic [CACHE_ID_W-1:0]        req_cache_id_i;
  req_op_e                      req_op_i;
  logic [CACHE_ADDR_W-1:0]      req_addr_i;
  logic [NUM_CHANNELS_USED-1:0] dram_v_o;
  req_op_e                      dram_op_o;
  logic [BG_W-1:0]              dram_bg_o;
  logic [BA_W-1:0]              dram_ba_o;
  logic [RO_W-1:0]              dram_ro_o;
  logic [CO_W-1:0]              dram_co_o;
  logic [BYTE_OFFSET_W-1:0]     dram_byte_offset_o;
  logic [GLOBAL_CTR_W-1:0]      dram_timestamp_o;

  // reference model, one entry per request in flight
  logic [CACHE_ID_W-1:0]   exp_id[$];
  req_op_e                 exp_op[$];
  logic [CACHE_ADDR_W-1:0] exp_addr[$];
  int unsigned             exp_edge[$];

  int unsigned             cycle     = 0;
  int unsigned             errors    = 0;
  int unsigned             checks    = 0;
  int unsigned             received  = 0;
  bit                      have_prev = 1'b0;
  logic [GLOBAL_CTR_W-1:0] prev_ts;
  int unsigned             prev_edge;

  mem_route_top uut (.*);

  initial begin
    core_clk = 1'b0;
    forever #50 core_clk = ~core_clk;
  end

  task automatic report_mismatch(input string msg);
    $display("FAILED %0t: %s", $time, msg);
    errors++;
  endtask

  // called on the falling edge, the strobe is sampled at the next rising edge
  task automatic drive_request();
    req_v_i        = 1'b1;
    req_cache_id_i = CACHE_ID_W'($urandom_range(0, NUM_CACHE - 1));
    req_op_i       = req_op_e'($urandom_range(0, 1));
    req_addr_i     = CACHE_ADDR_W'($urandom);
    exp_id.push_back(req_cache_id_i);
    exp_op.push_back(req_op_i);
    exp_addr.push_back(req_addr_i);
    exp_edge.push_back(cycle + 1);
    @(negedge core_clk);
    req_v_i = 1'b0;
  endtask

  task automatic check_output();
    logic [CACHE_ID_W-1:0]        id;
    req_op_e                      op;
    logic [CACHE_ADDR_W-1:0]      addr;
    int unsigned                  edge_n;
    logic [NUM_CHANNELS_USED-1:0] exp_v;
    checks++;
    if (exp_id.size() == 0) begin
      $display("unexpected output on dram_v_o=%b at %0t with no request pending",
               dram_v_o, $time);
      errors++;
      return;
    end
    id     = exp_id.pop_front();
    op     = exp_op.pop_front();
    addr   = exp_addr.pop_front();
    edge_n = exp_edge.pop_front();
    exp_v  = NUM_CHANNELS_USED'(1) << (id / CACHES_PER_CHANNEL);
    if (cycle != edge_n + PIPE_LATENCY)
      report_mismatch($sformatf("output at edge %0d, expected %0d", cycle,
                                edge_n + PIPE_LATENCY));
    if (dram_v_o != exp_v)
      report_mismatch($sformatf("dram_v_o %b, expected %b", dram_v_o, exp_v));
    if (dram_op_o != op)
      report_mismatch($sformatf("dram_op_o %0d, expected %0d", dram_op_o, op));
    if (dram_bg_o != BG_W'(id % CACHES_PER_CHANNEL))
      report_mismatch($sformatf("dram_bg_o %0d for cache %0d", dram_bg_o, id));
    if (dram_ba_o != addr[CACHE_ADDR_W-1 -: BA_W])
      report_mismatch($sformatf("dram_ba_o %0h, addr %0h", dram_ba_o, addr));
    if (dram_ro_o != addr[CACHE_ADDR_W-BA_W-1 -: RO_W])
      report_mismatch($sformatf("dram_ro_o %0h, addr %0h", dram_ro_o, addr));
    if (dram_co_o != addr[BYTE_OFFSET_W +: CO_W])
      report_mismatch($sformatf("dram_co_o %0h, addr %0h", dram_co_o, addr));
    if (dram_byte_offset_o != addr[BYTE_OFFSET_W-1:0])
      report_mismatch($sformatf("dram_byte_offset_o %0h, addr %0h", dram_byte_offset_o, addr));
    // timestamps advance with the distance between the input strobes
    if (have_prev && (dram_timestamp_o <= prev_ts))
      report_mismatch($sformatf("timestamp %0d not above %0d", dram_timestamp_o, prev_ts));
    if (have_prev && (dram_timestamp_o - prev_ts != GLOBAL_CTR_W'(edge_n - prev_edge)))
      report_mismatch($sformatf("timestamp step %0d, expected %0d",
                                dram_timestamp_o - prev_ts, edge_n - prev_edge));
    prev_ts   = dram_timestamp_o;
    prev_edge = edge_n;
    have_prev = 1'b1;
    received++;
  endtask

  // --------------------------------------------------
  // output monitor and timeout
  // --------------------------------------------------
  always @(posedge core_clk) begin
    cycle = cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Errors found");
      $finish;
    end else if (dram_v_o != '0) begin
      check_output();
    end
  end

  initial begin
    int unsigned gap;
    void'($urandom(SEED));
    reset_i        = 1'b1;
    req_v_i        = 1'b0;
    req_cache_id_i = '0;
    req_op_i       = OP_READ;
    req_addr_i     = '0;
    repeat (RESET_CYCLES) @(negedge core_clk);
    reset_i = 1'b0;

    // idle after reset, any output here is flagged by the monitor
    repeat (6) @(negedge core_clk);
    $display("test 1 idle after reset: finished, %0d errors so far", errors);

    // gap of zero gives back-to-back strobes
    for (int i = 0; i < NUM_REQ; i++) begin
      drive_request();
      gap = $urandom_range(0, 3);
      repeat (gap) @(negedge core_clk);
    end
    $display("test 2 random requests: finished, %0d errors so far", errors);

    while (received < NUM_REQ) @(posedge core_clk);
    repeat (PIPE_LATENCY + 2) @(negedge core_clk);
    // one output per request, nothing extra after the drain
    if (checks != NUM_REQ) begin
      $display("%0d outputs seen for %0d requests", checks, NUM_REQ);
      errors++;
    end
    $display("test 3 drain: finished, %0d errors so far", errors);

    $display("summary: %0d requests, %0d outputs checked, %0d errors",
             NUM_REQ, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
